/* reg_pkg.sv */
package reg_pkg;

    // Register file geometry
    localparam int NUM_PHYS_REGS = 16;
    localparam int WORD_W        = 32;
    localparam int PREG_W        = $clog2(NUM_PHYS_REGS);
    localparam int NZCV_W        = 4;

    // Data word held in every physical register
    typedef logic [WORD_W-1:0] word_t;

    // Physical register index
    typedef logic [PREG_W-1:0] preg_t;

    // Flag nibble, N in bit 3 down to V in bit 0
    typedef logic [NZCV_W-1:0] nzcv_t;

    // Bit positions inside the flag nibble
    localparam int NZCV_N = 3;
    localparam int NZCV_Z = 2;
    localparam int NZCV_C = 1;
    localparam int NZCV_V = 0;

    // ALU operations
    typedef enum logic [2:0] {
        OP_LOADI = 3'd0,  // dest <= imm, no flags
        OP_ADD   = 3'd1,
        OP_SUB   = 3'd2,
        OP_AND   = 3'd3,
        OP_XOR   = 3'd4
    } alu_op_t;

    // Issue stage FSM
    typedef enum logic [1:0] {
        ISS_IDLE = 2'd0,  // Accepting a new instruction
        ISS_HOLD = 2'd1,  // First look at the scoreboard
        ISS_WAIT = 2'd2   // Stalled on a pending register
    } issue_state_t;

endpackage

/* reg_file.sv */
module reg_file (
    input  logic                                clk,
    input  logic                                rst,
    // Read ports, combinational
    input  logic                                rd_en_a,
    input  reg_pkg::preg_t                      rd_idx_a,
    input  logic                                rd_en_b,
    input  reg_pkg::preg_t                      rd_idx_b,
    // Scoreboard clears from issue
    input  logic                                clr_en,
    input  reg_pkg::preg_t                      clr_idx,
    input  logic                                clr_flag_en,
    input  reg_pkg::preg_t                      clr_flag_idx,
    // Result write port
    input  logic                                wb_en,
    input  reg_pkg::preg_t                      wb_idx,
    input  reg_pkg::word_t                      wb_data,
    // NZCV write port
    input  logic                                nzcv_valid,
    input  reg_pkg::preg_t                      nzcv_idx,
    input  reg_pkg::nzcv_t                      nzcv,
    output reg_pkg::word_t                      rd_data_a,
    output reg_pkg::word_t                      rd_data_b,
    output logic [reg_pkg::NUM_PHYS_REGS-1:0]   scoreboard  // 1 = value valid
);

    reg_pkg::word_t registers [reg_pkg::NUM_PHYS_REGS];

    // Disabled ports read as zero
    always_comb begin
        rd_data_a = rd_en_a ? registers[rd_idx_a] : '0;
        rd_data_b = rd_en_b ? registers[rd_idx_b] : '0;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            // All registers zero and valid so the first instructions can issue
            for (int i = 0; i < reg_pkg::NUM_PHYS_REGS; i++) begin
                registers[i]  <= '0;
                scoreboard[i] <= 1'b1;
            end
        end else begin
            for (int i = 0; i < reg_pkg::NUM_PHYS_REGS; i++) begin
                // Issued destinations go pending
                if (clr_en && clr_idx == reg_pkg::preg_t'(i)) begin
                    scoreboard[i] <= 1'b0;
                end
                if (clr_flag_en && clr_flag_idx == reg_pkg::preg_t'(i)) begin
                    scoreboard[i] <= 1'b0;
                end
                // Writeback fills the register and marks it valid again
                if (wb_en && wb_idx == reg_pkg::preg_t'(i)) begin
                    registers[i]  <= wb_data;
                    scoreboard[i] <= 1'b1;
                end
                if (nzcv_valid && nzcv_idx == reg_pkg::preg_t'(i)) begin
                    registers[i]  <= reg_pkg::word_t'(nzcv);  // Zero-extended nibble
                    scoreboard[i] <= 1'b1;
                end
            end
        end
    end

    // Result and flags of one op always land in different registers
    a_wb_nzcv_distinct: assert property (@(posedge clk) disable iff (!rst)
        (wb_en && nzcv_valid) |-> (wb_idx != nzcv_idx));

    // Writes only complete what issue marked pending earlier
    a_wb_pending: assert property (@(posedge clk) disable iff (!rst)
        wb_en |-> !scoreboard[wb_idx]);
    a_nzcv_pending: assert property (@(posedge clk) disable iff (!rst)
        nzcv_valid |-> !scoreboard[nzcv_idx]);

    // Issue never reclaims a register whose write is landing this cycle
    a_clr_no_write: assert property (@(posedge clk) disable iff (!rst)
        clr_en |-> !(wb_en && wb_idx == clr_idx) && !(nzcv_valid && nzcv_idx == clr_idx));
    a_clr_flag_no_write: assert property (@(posedge clk) disable iff (!rst)
        clr_flag_en |-> !(wb_en && wb_idx == clr_flag_idx)
                        && !(nzcv_valid && nzcv_idx == clr_flag_idx));

endmodule

/* issue_stage.sv */
module issue_stage (
    input  logic                                clk,
    input  logic                                rst,
    // Valid/ready instruction input
    input  logic                                in_valid,
    input  reg_pkg::alu_op_t                    in_op,
    input  reg_pkg::preg_t                      in_dest,
    input  reg_pkg::preg_t                      in_flag_dest,
    input  reg_pkg::preg_t                      in_src_a,
    input  reg_pkg::preg_t                      in_src_b,
    input  reg_pkg::word_t                      in_imm,
    output logic                                in_ready,
    // Register file read and scoreboard
    input  logic [reg_pkg::NUM_PHYS_REGS-1:0]   scoreboard,
    input  reg_pkg::word_t                      rd_data_a,
    input  reg_pkg::word_t                      rd_data_b,
    output logic                                rd_en_a,
    output reg_pkg::preg_t                      rd_idx_a,
    output logic                                rd_en_b,
    output reg_pkg::preg_t                      rd_idx_b,
    output logic                                clr_en,
    output reg_pkg::preg_t                      clr_idx,
    output logic                                clr_flag_en,
    output reg_pkg::preg_t                      clr_flag_idx,
    // Toward the ALU
    output logic                                iss_valid,
    output reg_pkg::alu_op_t                    iss_op,
    output reg_pkg::preg_t                      iss_dest,
    output reg_pkg::preg_t                      iss_flag_dest,
    output reg_pkg::word_t                      iss_a,
    output reg_pkg::word_t                      iss_b
);

    reg_pkg::issue_state_t state;

    // Held instruction
    reg_pkg::alu_op_t hold_op;
    reg_pkg::preg_t   hold_dest;
    reg_pkg::preg_t   hold_flag_dest;
    reg_pkg::preg_t   hold_src_a;
    reg_pkg::preg_t   hold_src_b;
    reg_pkg::word_t   hold_imm;

    logic held;      // An instruction sits in HOLD or WAIT
    logic is_loadi;
    logic uses_regs; // Sources and flag register matter
    logic ready;     // Every needed scoreboard bit is set
    logic send;

    assign held      = (state != reg_pkg::ISS_IDLE);
    assign is_loadi  = (hold_op == reg_pkg::OP_LOADI);
    assign uses_regs = !is_loadi;

    assign ready = scoreboard[hold_dest]
                && (!uses_regs || scoreboard[hold_src_a])
                && (!uses_regs || scoreboard[hold_src_b])
                && (!uses_regs || scoreboard[hold_flag_dest]);

    assign send     = held && ready;
    assign in_ready = (state == reg_pkg::ISS_IDLE);

    // Operand reads follow the held sources
    assign rd_en_a  = held && uses_regs;
    assign rd_idx_a = hold_src_a;
    assign rd_en_b  = held && uses_regs;
    assign rd_idx_b = hold_src_b;

    // Destinations go pending on the issue edge
    assign clr_en       = send;
    assign clr_idx      = hold_dest;
    assign clr_flag_en  = send && uses_regs;
    assign clr_flag_idx = hold_flag_dest;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= reg_pkg::ISS_IDLE;
            iss_valid <= 1'b0;
        end else begin
            iss_valid <= send;
            case (state)
                reg_pkg::ISS_IDLE: if (in_valid) state <= reg_pkg::ISS_HOLD;
                reg_pkg::ISS_HOLD: state <= ready ? reg_pkg::ISS_IDLE : reg_pkg::ISS_WAIT;
                reg_pkg::ISS_WAIT: if (ready) state <= reg_pkg::ISS_IDLE;
                default:           state <= reg_pkg::ISS_IDLE;
            endcase
        end
    end

    // Capture the instruction on accept
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            hold_op        <= in_op;
            hold_dest      <= in_dest;
            hold_flag_dest <= in_flag_dest;
            hold_src_a     <= in_src_a;
            hold_src_b     <= in_src_b;
            hold_imm       <= in_imm;
        end
        if (send) begin
            iss_op        <= hold_op;
            iss_dest      <= hold_dest;
            iss_flag_dest <= hold_flag_dest;
            iss_a         <= is_loadi ? hold_imm : rd_data_a; // Immediate rides on a
            iss_b         <= rd_data_b;                       // Zero for load-immediate
        end
    end

    // Flags must not overwrite the result of the same op
    a_flag_dest_distinct: assert property (@(posedge clk) disable iff (!rst)
        (in_valid && in_ready && in_op != reg_pkg::OP_LOADI) |-> (in_flag_dest != in_dest));

endmodule

/* alu_stage.sv */
module alu_stage (
    input  logic                clk,
    input  logic                rst,
    // From issue
    input  logic                iss_valid,
    input  reg_pkg::alu_op_t    iss_op,
    input  reg_pkg::preg_t      iss_dest,
    input  reg_pkg::preg_t      iss_flag_dest,
    input  reg_pkg::word_t      iss_a,
    input  reg_pkg::word_t      iss_b,
    // Result writeback
    output logic                wb_en,
    output reg_pkg::preg_t      wb_idx,
    output reg_pkg::word_t      wb_data,
    // Flag writeback
    output logic                nzcv_valid,
    output reg_pkg::preg_t      nzcv_idx,
    output reg_pkg::nzcv_t      nzcv
);

    // Stage 1 decode straight off the issue registers
    logic           is_arith;   // Add or subtract
    logic           is_sub;
    logic           writes_flags;
    reg_pkg::word_t opnd_b;     // b inverted for subtract
    logic           carry_in;

    // Stage 2 execute
    logic [reg_pkg::WORD_W:0] sum_ext;  // 33-bit sum keeps the carry
    reg_pkg::word_t           result;
    logic                     ovf;
    reg_pkg::nzcv_t           flags;

    always_comb begin
        is_sub       = (iss_op == reg_pkg::OP_SUB);
        is_arith     = (iss_op == reg_pkg::OP_ADD) || is_sub;
        writes_flags = (iss_op != reg_pkg::OP_LOADI);
        opnd_b       = is_sub ? ~iss_b : iss_b;  // a - b as a + ~b + 1
        carry_in     = is_sub;
    end

    always_comb begin
        sum_ext = {1'b0, iss_a} + {1'b0, opnd_b} + {{reg_pkg::WORD_W{1'b0}}, carry_in};

        case (iss_op)
            reg_pkg::OP_LOADI: result = iss_a;
            reg_pkg::OP_ADD,
            reg_pkg::OP_SUB:   result = sum_ext[reg_pkg::WORD_W-1:0];
            reg_pkg::OP_AND:   result = iss_a & iss_b;
            reg_pkg::OP_XOR:   result = iss_a ^ iss_b;
            default:           result = '0;
        endcase

        // Signed overflow when both addends agree in sign and the sum does not
        ovf = (iss_a[reg_pkg::WORD_W-1] == opnd_b[reg_pkg::WORD_W-1])
           && (sum_ext[reg_pkg::WORD_W-1] != iss_a[reg_pkg::WORD_W-1]);

        flags[reg_pkg::NZCV_N] = result[reg_pkg::WORD_W-1];
        flags[reg_pkg::NZCV_Z] = (result == '0);
        flags[reg_pkg::NZCV_C] = is_arith && sum_ext[reg_pkg::WORD_W]; // No borrow on sub
        flags[reg_pkg::NZCV_V] = is_arith && ovf;  // Logic ops clear C and V
    end

    // Writeback valids
    always_ff @(posedge clk) begin
        if (!rst) begin
            wb_en      <= 1'b0;
            nzcv_valid <= 1'b0;
        end else begin
            wb_en      <= iss_valid;
            nzcv_valid <= iss_valid && writes_flags; // Load-immediate leaves flags alone
        end
    end

    always_ff @(posedge clk) begin
        if (iss_valid) begin
            wb_idx   <= iss_dest;
            wb_data  <= result;
            nzcv_idx <= iss_flag_dest;
            nzcv     <= flags;
        end
    end

endmodule

/* core_backend.sv */
module core_backend (
    input  logic                clk,
    input  logic                rst,
    // Instruction input
    input  logic                in_valid,
    input  reg_pkg::alu_op_t    in_op,
    input  reg_pkg::preg_t      in_dest,
    input  reg_pkg::preg_t      in_flag_dest,
    input  reg_pkg::preg_t      in_src_a,
    input  reg_pkg::preg_t      in_src_b,
    input  reg_pkg::word_t      in_imm,
    output logic                in_ready,
    // Retire stream, no back-pressure
    output logic                retire_valid,
    output reg_pkg::preg_t      retire_dest,
    output reg_pkg::word_t      retire_data,
    output logic                retire_flag_valid,
    output reg_pkg::preg_t      retire_flag_dest,
    output reg_pkg::nzcv_t      retire_nzcv
);

    // Issue to register file
    logic                               rd_en_a;
    reg_pkg::preg_t                     rd_idx_a;
    logic                               rd_en_b;
    reg_pkg::preg_t                     rd_idx_b;
    reg_pkg::word_t                     rd_data_a;
    reg_pkg::word_t                     rd_data_b;
    logic [reg_pkg::NUM_PHYS_REGS-1:0]  scoreboard;
    logic                               clr_en;
    reg_pkg::preg_t                     clr_idx;
    logic                               clr_flag_en;
    reg_pkg::preg_t                     clr_flag_idx;

    // Issue to ALU
    logic                               iss_valid;
    reg_pkg::alu_op_t                   iss_op;
    reg_pkg::preg_t                     iss_dest;
    reg_pkg::preg_t                     iss_flag_dest;
    reg_pkg::word_t                     iss_a;
    reg_pkg::word_t                     iss_b;

    // ALU writeback
    logic                               wb_en;
    reg_pkg::preg_t                     wb_idx;
    reg_pkg::word_t                     wb_data;
    logic                               nzcv_valid;
    reg_pkg::preg_t                     nzcv_idx;
    reg_pkg::nzcv_t                     nzcv;

    issue_stage u_issue (
        .clk, .rst,
        .in_valid, .in_op, .in_dest, .in_flag_dest, .in_src_a, .in_src_b, .in_imm, .in_ready,
        .scoreboard, .rd_data_a, .rd_data_b,
        .rd_en_a, .rd_idx_a, .rd_en_b, .rd_idx_b,
        .clr_en, .clr_idx, .clr_flag_en, .clr_flag_idx,
        .iss_valid, .iss_op, .iss_dest, .iss_flag_dest, .iss_a, .iss_b
    );

    reg_file u_reg_file (
        .clk, .rst,
        .rd_en_a, .rd_idx_a, .rd_en_b, .rd_idx_b,
        .clr_en, .clr_idx, .clr_flag_en, .clr_flag_idx,
        .wb_en, .wb_idx, .wb_data,
        .nzcv_valid, .nzcv_idx, .nzcv,
        .rd_data_a, .rd_data_b, .scoreboard
    );

    alu_stage u_alu (
        .clk, .rst,
        .iss_valid, .iss_op, .iss_dest, .iss_flag_dest, .iss_a, .iss_b,
        .wb_en, .wb_idx, .wb_data,
        .nzcv_valid, .nzcv_idx, .nzcv
    );

    // Retire taps the writeback ports directly
    assign retire_valid      = wb_en;
    assign retire_dest       = wb_idx;
    assign retire_data       = wb_data;
    assign retire_flag_valid = nzcv_valid;
    assign retire_flag_dest  = nzcv_idx;
    assign retire_nzcv       = nzcv;

endmodule

/* tb_core_backend.sv */
module tb_core_backend;

    localparam int NUM_TESTS       = 20;
    localparam int RESET_CYCLES    = 3;
    localparam int CYCLES_PER_TEST = 20;  // Watchdog budget per table entry

    logic               clk = 1'b0;
    logic               rst;
    logic               in_valid;
    reg_pkg::alu_op_t   in_op;
    reg_pkg::preg_t     in_dest;
    reg_pkg::preg_t     in_flag_dest;
    reg_pkg::preg_t     in_src_a;
    reg_pkg::preg_t     in_src_b;
    reg_pkg::word_t     in_imm;
    logic               in_ready;
    logic               retire_valid;
    reg_pkg::preg_t     retire_dest;
    reg_pkg::word_t     retire_data;
    logic               retire_flag_valid;
    reg_pkg::preg_t     retire_flag_dest;
    reg_pkg::nzcv_t     retire_nzcv;

    // Instruction table with hand-computed results
    string              t_name      [NUM_TESTS];
    reg_pkg::alu_op_t   t_op        [NUM_TESTS];
    reg_pkg::preg_t     t_dest      [NUM_TESTS];
    reg_pkg::preg_t     t_flag_dest [NUM_TESTS];
    reg_pkg::preg_t     t_src_a     [NUM_TESTS];
    reg_pkg::preg_t     t_src_b     [NUM_TESTS];
    reg_pkg::word_t     t_imm       [NUM_TESTS];
    reg_pkg::word_t     t_exp_data  [NUM_TESTS];
    reg_pkg::nzcv_t     t_exp_nzcv  [NUM_TESTS];
    bit                 t_dep       [NUM_TESTS];  // 1 = must stall on the previous dest
    int                 num_entries = 0;

    int                 edge_count  = 0;   // Rising edges since time zero
    int                 accept_edge [NUM_TESTS];
    int                 last_accept = 0;
    int                 last_idx    = -1;
    bit                 stalled     [NUM_TESTS];

    core_backend u_core_backend (
        .clk, .rst,
        .in_valid, .in_op, .in_dest, .in_flag_dest, .in_src_a, .in_src_b, .in_imm, .in_ready,
        .retire_valid, .retire_dest, .retire_data,
        .retire_flag_valid, .retire_flag_dest, .retire_nzcv
    );

    always #2 clk = ~clk;

    always @(posedge clk) edge_count <= edge_count + 1;

    // in_ready low past the single HOLD cycle means the issue stage sits in WAIT
    always @(negedge clk) begin
        if (rst === 1'b1 && last_idx >= 0 && in_ready === 1'b0
            && edge_count >= last_accept + 1) begin
            stalled[last_idx] = 1'b1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic add_entry(input string name, input reg_pkg::alu_op_t op,
                             input reg_pkg::preg_t dest, input reg_pkg::preg_t flag_dest,
                             input reg_pkg::preg_t src_a, input reg_pkg::preg_t src_b,
                             input reg_pkg::word_t imm, input reg_pkg::word_t exp_data,
                             input reg_pkg::nzcv_t exp_nzcv, input bit dep);
        t_name[num_entries]      = name;
        t_op[num_entries]        = op;
        t_dest[num_entries]      = dest;
        t_flag_dest[num_entries] = flag_dest;
        t_src_a[num_entries]     = src_a;
        t_src_b[num_entries]     = src_b;
        t_imm[num_entries]       = imm;
        t_exp_data[num_entries]  = exp_data;
        t_exp_nzcv[num_entries]  = exp_nzcv;
        t_dep[num_entries]       = dep;
        num_entries++;
    endtask

    // Fields: name, op, dest, flag dest, src a, src b, imm, data, NZCV, dependent
    task automatic build_table;
        add_entry("reset_add", reg_pkg::OP_ADD, 4'd1, 4'd15, 4'd2, 4'd3, 32'h0,
                  32'h0000_0000, 4'b0100, 1'b0);  // Never-written regs read zero
        add_entry("loadi_a", reg_pkg::OP_LOADI, 4'd2, 4'd0, 4'd0, 4'd0, 32'h0000_1234,
                  32'h0000_1234, 4'b0000, 1'b0);
        add_entry("loadi_b", reg_pkg::OP_LOADI, 4'd3, 4'd0, 4'd0, 4'd0, 32'h0000_0F0F,
                  32'h0000_0F0F, 4'b0000, 1'b0);
        add_entry("add_basic", reg_pkg::OP_ADD, 4'd4, 4'd14, 4'd2, 4'd3, 32'h0,
                  32'h0000_2143, 4'b0000, 1'b1);  // p3 still in flight
        add_entry("loadi_max", reg_pkg::OP_LOADI, 4'd5, 4'd0, 4'd0, 4'd0, 32'hFFFF_FFFF,
                  32'hFFFF_FFFF, 4'b0000, 1'b0);
        add_entry("loadi_one", reg_pkg::OP_LOADI, 4'd6, 4'd0, 4'd0, 4'd0, 32'h0000_0001,
                  32'h0000_0001, 4'b0000, 1'b0);
        add_entry("add_carry", reg_pkg::OP_ADD, 4'd7, 4'd13, 4'd5, 4'd6, 32'h0,
                  32'h0000_0000, 4'b0110, 1'b1);  // Wraps to zero with carry out
        add_entry("loadi_smax", reg_pkg::OP_LOADI, 4'd8, 4'd0, 4'd0, 4'd0, 32'h7FFF_FFFF,
                  32'h7FFF_FFFF, 4'b0000, 1'b0);
        add_entry("add_ovf", reg_pkg::OP_ADD, 4'd9, 4'd12, 4'd8, 4'd6, 32'h0,
                  32'h8000_0000, 4'b1001, 1'b1);  // Largest positive plus one
        add_entry("sub_equal", reg_pkg::OP_SUB, 4'd10, 4'd11, 4'd2, 4'd2, 32'h0,
                  32'h0000_0000, 4'b0110, 1'b0);  // No borrow gives C
        add_entry("sub_borrow", reg_pkg::OP_SUB, 4'd1, 4'd15, 4'd3, 4'd2, 32'h0,
                  32'hFFFF_FCDB, 4'b1000, 1'b0);  // 0x0F0F - 0x1234
        add_entry("and_sign", reg_pkg::OP_AND, 4'd12, 4'd0, 4'd5, 4'd9, 32'h0,
                  32'h8000_0000, 4'b1000, 1'b0);
        add_entry("xor_self", reg_pkg::OP_XOR, 4'd13, 4'd14, 4'd3, 4'd3, 32'h0,
                  32'h0000_0000, 4'b0100, 1'b0);
        add_entry("xor_mix", reg_pkg::OP_XOR, 4'd4, 4'd0, 4'd5, 4'd2, 32'h0,
                  32'hFFFF_EDCB, 4'b1000, 1'b0);
        // Chain, each op reads the previous dest
        add_entry("chain_0", reg_pkg::OP_LOADI, 4'd1, 4'd0, 4'd0, 4'd0, 32'h0000_0010,
                  32'h0000_0010, 4'b0000, 1'b0);
        add_entry("chain_1", reg_pkg::OP_ADD, 4'd2, 4'd15, 4'd1, 4'd1, 32'h0,
                  32'h0000_0020, 4'b0000, 1'b1);
        add_entry("chain_2", reg_pkg::OP_ADD, 4'd3, 4'd14, 4'd2, 4'd1, 32'h0,
                  32'h0000_0030, 4'b0000, 1'b1);
        add_entry("chain_3", reg_pkg::OP_SUB, 4'd4, 4'd13, 4'd3, 4'd2, 32'h0,
                  32'h0000_0010, 4'b0010, 1'b1);
        add_entry("chain_4", reg_pkg::OP_XOR, 4'd5, 4'd12, 4'd4, 4'd1, 32'h0,
                  32'h0000_0000, 4'b0100, 1'b1);
        add_entry("indep_after", reg_pkg::OP_AND, 4'd6, 4'd7, 4'd8, 4'd8, 32'h0,
                  32'h7FFF_FFFF, 4'b0000, 1'b0);
    endtask

    // Fields change on the falling edge, transfer lands on the next rising edge
    task automatic drive_instructions;
        for (int i = 0; i < num_entries; i++) begin
            in_valid     = 1'b1;
            in_op        = t_op[i];
            in_dest      = t_dest[i];
            in_flag_dest = t_flag_dest[i];
            in_src_a     = t_src_a[i];
            in_src_b     = t_src_b[i];
            in_imm       = t_imm[i];
            while (in_ready !== 1'b1) @(negedge clk);
            accept_edge[i] = edge_count + 1;
            last_accept    = edge_count + 1;
            last_idx       = i;
            @(negedge clk);
        end
        in_valid = 1'b0;
    endtask

    task automatic monitor_retire;
        for (int r = 0; r < num_entries; r++) begin
            @(negedge clk);
            while (retire_valid !== 1'b1) @(negedge clk);
            check_value({t_name[r], " dest"}, t_dest[r], retire_dest);
            check_value({t_name[r], " data"}, t_exp_data[r], retire_data);
            // Load-immediate leaves the flag port idle
            check_value({t_name[r], " flag valid"}, t_op[r] != reg_pkg::OP_LOADI,
                        retire_flag_valid);
            if (t_op[r] != reg_pkg::OP_LOADI) begin
                check_value({t_name[r], " flag dest"}, t_flag_dest[r], retire_flag_dest);
                check_value({t_name[r], " nzcv"}, t_exp_nzcv[r], retire_nzcv);
            end
            check_value({t_name[r], " stall"}, t_dep[r], stalled[r]);
            if (!t_dep[r]) begin
                check_value({t_name[r], " latency"}, 2, edge_count - accept_edge[r]);
            end
        end
    endtask

    // Nothing may retire once the table is used up
    task automatic check_quiet_tail;
        repeat (4) begin
            @(negedge clk);
            check_value("no extra retire", 1'b0, retire_valid);
        end
    endtask

    task automatic run_watchdog;
        repeat (RESET_CYCLES + CYCLES_PER_TEST * NUM_TESTS) @(posedge clk);
        $display("Timeout: retirement stalled before all instructions completed");
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    endtask

    initial begin
        rst          = 1'b0;
        in_valid     = 1'b0;
        in_op        = reg_pkg::OP_LOADI;
        in_dest      = '0;
        in_flag_dest = '0;
        in_src_a     = '0;
        in_src_b     = '0;
        in_imm       = '0;
        build_table();
        fork
            run_watchdog();
        join_none
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        fork
            drive_instructions();
            monitor_retire();
        join
        check_quiet_tail();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* vlog.f */
reg_pkg.sv
reg_file.sv
issue_stage.sv
alu_stage.sv
core_backend.sv
tb_core_backend.sv

/* Bender.yml */
package:
  name: core_backend

sources:
  - reg_pkg.sv
  - reg_file.sv
  - issue_stage.sv
  - alu_stage.sv
  - core_backend.sv
  - target: simulation
    files:
      - tb_core_backend.sv
